//--- all.f
design/pinbus_pkg.sv
design/frame_sequencer.sv
design/byte_lane.sv
design/pin_mux.sv
design/pinbus_bridge.sv
test/pin_device_model.sv
test/pinbus_bridge_tb.sv

//--- design/byte_lane.sv
// byte lane: one byte of address, write data and read data for the frame
`default_nettype none

module byte_lane #(
  parameter int LANE = 0
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          load,
  input  wire pinbus_pkg::addr_t       addr,
  input  wire pinbus_pkg::word_t       wdata,
  input  wire pinbus_pkg::slot_t       slot,
  input  wire                          capture,
  input  wire pinbus_pkg::lane_idx_t   capture_lane,
  input  wire pinbus_pkg::pin_byte_t   io_in,
  output pinbus_pkg::pin_byte_t        addr_byte,
  output pinbus_pkg::pin_byte_t        wdata_byte,
  output pinbus_pkg::pin_byte_t        rdata_byte,
  output logic                         active
);

  import pinbus_pkg::*;

  localparam int        LSB      = LANE * PIN_W;           // byte offset in the word
  localparam slot_t     OWN_SLOT = slot_t'(LANE + 1);      // address slot of this lane
  localparam lane_idx_t OWN_IDX  = lane_idx_t'(LANE);

  logic own_capture;

  // lane is on the pins while its address slot is current
  assign active = (slot == OWN_SLOT);

  assign own_capture = capture && (capture_lane == OWN_IDX);

  // request bytes, only taken at acceptance
  always_ff @(posedge clk) begin
    if (load) begin
      addr_byte  <= addr[LSB +: PIN_W];
      wdata_byte <= wdata[LSB +: PIN_W];
    end
  end

  // read byte stays put through writes
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata_byte <= '0;
    end else if (own_capture) begin
      rdata_byte <= io_in;
    end
  end

endmodule

`default_nettype wire

//--- design/frame_sequencer.sv
// frame sequencer: four-phase req/ack front end, slot counter, lane load and read capture strobes
`default_nettype none

module frame_sequencer (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    req,
  input  wire                    we,
  output logic                   ack,
  output pinbus_pkg::slot_t      slot,
  output logic                   load,
  output logic                   capture,
  output pinbus_pkg::lane_idx_t  capture_lane,
  output logic                   frame_we
);

  import pinbus_pkg::*;

  seq_state_t state;
  logic       accept;
  logic       last_slot;
  logic       read_slot;

  // a request is taken only once the previous ack has dropped
  assign accept = (state == SEQ_IDLE) && req && !ack;

  // lanes grab addr and wdata on the acceptance edge
  assign load = accept;

  assign last_slot = (slot == SLOT_LAST);

  // slot never passes SLOT_LAST, so no upper bound needed
  assign read_slot = (state == SEQ_FRAME) && (slot >= FIRST_READ_SLOT) && !frame_we;

  // main state machine and slot counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= SEQ_IDLE;
      slot     <= '0;
      ack      <= 1'b0;
      frame_we <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (accept) begin
            state    <= SEQ_FRAME;
            slot     <= slot_t'(1);  // first address slot
            frame_we <= we;          // held for the whole frame
          end
        end

        SEQ_FRAME: begin
          if (last_slot) begin
            slot  <= '0;
            state <= SEQ_ACK;
          end else begin
            slot <= slot + slot_t'(1);
          end
        end

        SEQ_ACK: begin
          // first edge here raises ack, the edge that sees req low drops it
          ack <= req;
          if (!req) begin
            state <= SEQ_IDLE;
          end
        end

        default: begin
          state <= SEQ_IDLE;
          slot  <= '0;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // capture trails the read slot by one cycle
  // the device drives byte n-6 from E(n), the lane samples it at E(n+1)
  always_ff @(posedge clk) begin
    if (reset) begin
      capture      <= 1'b0;
      capture_lane <= '0;
    end else begin
      capture      <= read_slot;
      capture_lane <= lane_idx_t'(slot - FIRST_READ_SLOT);  // slot 6 -> lane 0
    end
  end

endmodule

`default_nettype wire

//--- design/pin_mux.sv
// pin multiplexer: picks the active lane or the control byte and registers it onto the pins
`default_nettype none

module pin_mux (
  input  wire                         clk,
  input  wire                         reset,
  input  wire pinbus_pkg::slot_t      slot,
  input  wire                         frame_we,
  input  wire [pinbus_pkg::LANES-1:0] lane_active,
  input  wire pinbus_pkg::pin_byte_t  lane_addr  [pinbus_pkg::LANES],
  input  wire pinbus_pkg::pin_byte_t  lane_wdata [pinbus_pkg::LANES],
  output pinbus_pkg::pin_byte_t       out_pins,
  output pinbus_pkg::pin_byte_t       io_out,
  output pinbus_pkg::pin_byte_t       io_oe,
  output logic                        sync
);

  import pinbus_pkg::*;

  pin_byte_t sel_addr;
  pin_byte_t sel_wdata;
  pin_byte_t out_next;
  pin_byte_t io_next;
  pin_byte_t oe_next;
  logic      addr_slot;
  logic      ctrl_slot;
  logic      sync_next;

  // at most one lane is active, so an or-reduce is enough
  always_comb begin
    sel_addr  = '0;
    sel_wdata = '0;
    for (int i = 0; i < LANES; i++) begin
      if (lane_active[i]) begin
        sel_addr  = sel_addr | lane_addr[i];
        sel_wdata = sel_wdata | lane_wdata[i];
      end
    end
  end

  assign addr_slot = |lane_active;
  assign ctrl_slot = (slot == SLOT_CTRL);
  assign sync_next = (slot == slot_t'(1));  // first pin cycle of the frame

  always_comb begin
    out_next = '0;
    io_next  = '0;
    oe_next  = '0;
    if (addr_slot) begin
      out_next = sel_addr;
      io_next  = frame_we ? sel_wdata : '0;  // data bytes ride along on writes only
      oe_next  = {PIN_W{frame_we}};
    end else if (ctrl_slot) begin
      out_next = {{(PIN_W-1){1'b0}}, frame_we};
      oe_next  = {PIN_W{frame_we}};
    end
    // read slots and idle leave everything at zero
  end

  // slot n shows on the pins one cycle after the counter reaches it
  always_ff @(posedge clk) begin
    if (reset) begin
      out_pins <= '0;
      io_out   <= '0;
      io_oe    <= '0;
      sync     <= 1'b0;
    end else begin
      out_pins <= out_next;
      io_out   <= io_next;
      io_oe    <= oe_next;
      sync     <= sync_next;
    end
  end

endmodule

`default_nettype wire

//--- design/pinbus_bridge.sv
// pin bus bridge top: sequencer, four byte lanes and the pin multiplexer
`default_nettype none

module pinbus_bridge (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         req,
  input  wire                         we,
  input  wire pinbus_pkg::addr_t      addr,
  input  wire pinbus_pkg::word_t      wdata,
  output logic                        ack,
  output pinbus_pkg::word_t           rdata,
  output pinbus_pkg::pin_byte_t       out_pins,
  output pinbus_pkg::pin_byte_t       io_out,
  output pinbus_pkg::pin_byte_t       io_oe,
  input  wire pinbus_pkg::pin_byte_t  io_in,
  output logic                        sync
);

  import pinbus_pkg::*;

  slot_t            slot;
  logic             load;
  logic             capture;
  lane_idx_t        capture_lane;
  logic             frame_we;
  logic [LANES-1:0] lane_active;
  pin_byte_t        lane_addr  [LANES];
  pin_byte_t        lane_wdata [LANES];

  frame_sequencer u_seq (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .we           (we),
    .ack          (ack),
    .slot         (slot),
    .load         (load),
    .capture      (capture),
    .capture_lane (capture_lane),
    .frame_we     (frame_we)
  );

  // lane i owns byte i of addr, wdata and rdata
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    byte_lane #(
      .LANE (i)
    ) u_lane (
      .clk          (clk),
      .reset        (reset),
      .load         (load),
      .addr         (addr),
      .wdata        (wdata),
      .slot         (slot),
      .capture      (capture),
      .capture_lane (capture_lane),
      .io_in        (io_in),
      .addr_byte    (lane_addr[i]),
      .wdata_byte   (lane_wdata[i]),
      .rdata_byte   (rdata[i*PIN_W +: PIN_W]),
      .active       (lane_active[i])
    );
  end

  pin_mux u_mux (
    .clk         (clk),
    .reset       (reset),
    .slot        (slot),
    .frame_we    (frame_we),
    .lane_active (lane_active),
    .lane_addr   (lane_addr),
    .lane_wdata  (lane_wdata),
    .out_pins    (out_pins),
    .io_out      (io_out),
    .io_oe       (io_oe),
    .sync        (sync)
  );

endmodule

`default_nettype wire

//--- design/pinbus_pkg.sv
// pin bus bridge package: widths, vector types, frame slot numbers and sequencer states
`default_nettype none

package pinbus_pkg;

  // widths of the processor side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // pin side widths
  localparam int PIN_W  = 8;
  localparam int SLOT_W = 4;
  localparam int LANE_W = 2;

  localparam int LANES = DATA_W / PIN_W;  // one lane per byte of the word

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [PIN_W-1:0]  pin_byte_t;
  typedef logic [SLOT_W-1:0] slot_t;      // 0 means no slot
  typedef logic [LANE_W-1:0] lane_idx_t;

  // frame layout
  // slots 1..4 carry address and write data, lane n in slot n+1
  localparam slot_t SLOT_CTRL       = 4'd5;  // write flag in bit 0
  localparam slot_t FIRST_READ_SLOT = 4'd6;
  localparam slot_t SLOT_LAST       = 4'd9;

  // frame sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,  // waiting for req
    SEQ_FRAME = 2'd1,  // slot counter running
    SEQ_ACK   = 2'd2   // ack high until req drops
  } seq_state_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the pin bus bridge simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module pinbus_bridge_tb -o pinbus_sim
./obj_dir/pinbus_sim

//--- test/pin_device_model.sv
// pin-side device model: decodes bridge frames, records writes and answers reads on io_in
`default_nettype none

module pin_device_model (
  input  wire                        clk,
  input  wire                        reset,
  input  wire pinbus_pkg::pin_byte_t out_pins,
  input  wire pinbus_pkg::pin_byte_t io_out,
  input  wire pinbus_pkg::pin_byte_t io_oe,
  input  wire                        sync,
  input  wire pinbus_pkg::word_t     read_word,
  output pinbus_pkg::pin_byte_t      io_in,
  output pinbus_pkg::addr_t          frame_addr,
  output pinbus_pkg::pin_byte_t      frame_ctrl,
  output pinbus_pkg::addr_t          wr_addr,
  output pinbus_pkg::word_t          wr_data,
  output int                         frames
);
  timeunit 1ns;
  timeprecision 1ps;

  import pinbus_pkg::*;

  // called in pin cycle 1, returns in pin cycle 5 (write) or after the read bytes
  task automatic decode_frame();
    addr_t a;
    word_t d;
    a = '0;
    d = '0;
    for (int k = 0; k < LANES; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      a[k*PIN_W +: PIN_W] = out_pins;
      d[k*PIN_W +: PIN_W] = io_out & io_oe;  // only bits the bridge drives
    end
    @(negedge clk);  // control slot
    frame_ctrl = out_pins;
    frame_addr = a;
    frames     = frames + 1;
    if (out_pins[0]) begin
      wr_addr = a;
      wr_data = d;
    end else begin
      // byte for pin cycle n goes out at E(n), starting with pin cycle 6
      for (int k = 0; k < LANES; k++) begin
        @(posedge clk);
        io_in <= read_word[k*PIN_W +: PIN_W];
      end
      @(posedge clk);
      io_in <= '0;  // bus idle again after pin cycle 9
    end
  endtask

  initial begin
    io_in      = '0;
    frame_addr = '0;
    frame_ctrl = '0;
    wr_addr    = '0;
    wr_data    = '0;
    frames     = 0;
    forever begin
      @(negedge clk);
      if (!reset && sync) begin
        decode_frame();
      end
    end
  end

endmodule

`default_nettype wire

//--- test/pinbus_bridge_tb.sv
// testbench for the pin bus bridge: random reads and writes against a pin-side device model
`default_nettype none

module pinbus_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import pinbus_pkg::*;

  localparam int N_TXN      = 200;
  localparam int TXN_CYCLES = 20;  // 14 fixed, up to 5 of req hold, rounded up
  localparam int MAX_CYCLES = N_TXN * TXN_CYCLES + 100;

  logic      clk;
  logic      reset;
  logic      req;
  logic      we;
  addr_t     addr;
  word_t     wdata;
  logic      ack;
  word_t     rdata;
  pin_byte_t out_pins;
  pin_byte_t io_out;
  pin_byte_t io_oe;
  pin_byte_t io_in;
  logic      sync;

  // what the device saw
  word_t     dev_read_word;
  addr_t     dev_addr;
  pin_byte_t dev_ctrl;
  addr_t     dev_wr_addr;
  word_t     dev_wr_data;
  int        dev_frames;

  int          cyc       = 0;     // rising edges so far
  int          e0_cyc    = -100;  // acceptance edge of the current frame
  logic        exp_we    = 1'b0;
  addr_t       exp_addr  = '0;
  word_t       exp_wdata = '0;
  word_t       last_read = '0;
  int          done_txn  = 0;
  logic [31:0] rng       = 32'h3157_d9af;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // device read data: address rotated left by one byte, then a fixed mask
  function automatic word_t ref_read_data(input addr_t a);
    return {a[23:0], a[31:24]} ^ 32'ha5c3_0f96;
  endfunction

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_word(input word_t got, input word_t want, input string what);
    if (got !== want) begin
      $display("error: %0d ns, %s is %h, expected %h", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t want, input string what);
    if (got !== want) begin
      $display("error: %0d ns, %s is %h, expected %h", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic check_byte(input pin_byte_t got, input pin_byte_t want, input string what);
    if (got !== want) begin
      $display("error: %0d ns, %s is %h, expected %h", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("error: %0d ns, %s is %b, expected %b", $time, what, got, want);
      abort_run();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  pinbus_bridge UUT (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .ack      (ack),
    .rdata    (rdata),
    .out_pins (out_pins),
    .io_out   (io_out),
    .io_oe    (io_oe),
    .io_in    (io_in),
    .sync     (sync)
  );

  pin_device_model u_dev (
    .clk        (clk),
    .reset      (reset),
    .out_pins   (out_pins),
    .io_out     (io_out),
    .io_oe      (io_oe),
    .sync       (sync),
    .read_word  (dev_read_word),
    .io_in      (io_in),
    .frame_addr (dev_addr),
    .frame_ctrl (dev_ctrl),
    .wr_addr    (dev_wr_addr),
    .wr_data    (dev_wr_data),
    .frames     (dev_frames)
  );

  assign dev_read_word = ref_read_data(dev_addr);

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(negedge clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d clock cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // expected pins for pin cycle n = cycles since the acceptance edge
  task automatic check_pins();
    int        n;
    pin_byte_t e_out;
    pin_byte_t e_io;
    pin_byte_t e_oe;
    n     = cyc - e0_cyc;
    e_out = '0;
    e_io  = '0;
    e_oe  = '0;
    if (n >= 1 && n <= 4) begin
      e_out = exp_addr[(n-1)*PIN_W +: PIN_W];
      if (exp_we) begin
        e_io = exp_wdata[(n-1)*PIN_W +: PIN_W];
        e_oe = 8'hff;
      end
    end else if (n == 5) begin
      e_out = {7'b0, exp_we};
      e_oe  = exp_we ? 8'hff : 8'h00;
    end
    check_byte(out_pins, e_out, $sformatf("out_pins in pin cycle %0d", n));
    check_byte(io_out, e_io, $sformatf("io_out in pin cycle %0d", n));
    check_byte(io_oe, e_oe, $sformatf("io_oe in pin cycle %0d", n));
    check_bit(sync, n == 1, $sformatf("sync in pin cycle %0d", n));
  endtask

  always @(negedge clk) begin
    if (cyc > 0) begin
      check_pins();
    end
  end

  task automatic run_transaction(input logic w, input addr_t a, input word_t d, input int hold);
    int lat;
    @(posedge clk);
    req       <= 1'b1;
    we        <= w;
    addr      <= a;
    wdata     <= d;
    e0_cyc    <= cyc + 2;  // accepted on the next edge
    exp_we    <= w;
    exp_addr  <= a;
    exp_wdata <= d;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    lat = cyc - e0_cyc;
    if (lat != 10) begin
      $display("error: %0d ns, ack latency is %0d cycles, expected 10", $time, lat);
      abort_run();
    end
    if (dev_frames != done_txn + 1) begin
      $display("device decoded %0d frames but %0d were sent", dev_frames, done_txn + 1);
      abort_run();
    end
    check_addr(dev_addr, a, "device frame address");
    check_byte(dev_ctrl, {7'b0, w}, "control byte");
    if (w) begin
      check_addr(dev_wr_addr, a, "device write address");
      check_word(dev_wr_data, d, "device write data");
      check_word(rdata, last_read, "rdata after write");
    end else begin
      last_read = ref_read_data(a);
      check_word(rdata, last_read, "read data");
    end
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit(ack, 1'b1, "ack while req held");
    end
    @(posedge clk);
    req   <= 1'b0;
    addr  <= ~a;  // processor side is free to change once req is low
    wdata <= ~d;
    @(negedge clk);
    check_bit(ack, 1'b1, "ack on the edge that drops req");
    @(negedge clk);
    check_bit(ack, 1'b0, "ack after req seen low");
    done_txn = done_txn + 1;
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    word_t       d;
    int          hold;
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int t = 0; t < N_TXN; t++) begin
      rng  = xorshift(rng);
      a    = rng;
      rng  = xorshift(rng);
      d    = rng;
      rng  = xorshift(rng);
      r    = rng;
      hold = int'(r[31:8] % 24'd6);  // upper bits, independent of the write flag
      run_transaction(r[0], a, d, hold);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
